//--- verilog/rename_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, counts and index types of the integer rename stage
// Reset values of the map and the free vector
//////////////////////////////////////////////////////////////////////

package rename_pkg;

  localparam int RENAME_WIDTH = 2;
  localparam int ARCH_REGS    = 32;
  localparam int PHYS_REGS    = 64;
  localparam int CKPT_SLOTS   = 4;

  typedef logic [$clog2(ARCH_REGS)-1:0]  arch_idx_t;
  typedef logic [$clog2(PHYS_REGS)-1:0]  phys_idx_t;
  typedef logic [$clog2(CKPT_SLOTS)-1:0] ckpt_idx_t;
  typedef logic [PHYS_REGS-1:0]          phys_vec_t;
  typedef logic [$clog2(PHYS_REGS):0]    free_count_t;
  typedef phys_idx_t [ARCH_REGS-1:0]     map_t;

  // Architectural register i starts on physical register i
  function automatic map_t identity_map();
    map_t m;
    for (int i = 0; i < ARCH_REGS; i++) begin
      m[i] = phys_idx_t'(i);
    end
    return m;
  endfunction

  localparam map_t        MAP_RESET        = identity_map();
  // Everything above the architectural range is free
  localparam phys_vec_t   FREE_RESET       = {{(PHYS_REGS - ARCH_REGS){1'b1}},
                                              {ARCH_REGS{1'b0}}};
  localparam free_count_t FREE_RESET_COUNT = free_count_t'(PHYS_REGS - ARCH_REGS);

endpackage

//--- verilog/ckpt_if.sv
//////////////////////////////////////////////////////////////////////
// Checkpoint bundle between map table, free list and snapshot store
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface ckpt_if;
  import rename_pkg::*;

  // Strobes and slot indices
  logic      save;
  ckpt_idx_t save_idx;
  logic      restore;
  ckpt_idx_t restore_idx;

  // Live state going in, saved state coming out
  map_t      map_snap_in;
  map_t      map_snap_out;
  phys_vec_t free_snap_in;
  phys_vec_t free_snap_out;

  modport store (
    input  save, save_idx, restore, restore_idx, map_snap_in, free_snap_in,
    output map_snap_out, free_snap_out
  );

  modport map_side (output map_snap_in, input map_snap_out);

  modport free_side (output free_snap_in, input restore, free_snap_out);

endinterface

//--- verilog/checkpoint_store.sv
//////////////////////////////////////////////////////////////////////
// Snapshot store with four slots
// Each slot holds a full map and a free vector
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module checkpoint_store (
  input logic   clock,
  input logic   reset,
  ckpt_if.store ckpt
);

  import rename_pkg::*;

  map_t      map_slot  [CKPT_SLOTS];
  phys_vec_t free_slot [CKPT_SLOTS];

  // Saved copy is the live state before this cycle's group
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < CKPT_SLOTS; i++) begin
        map_slot[i]  <= MAP_RESET;
        free_slot[i] <= FREE_RESET;
      end
    end else if (ckpt.save) begin
      map_slot[ckpt.save_idx]  <= ckpt.map_snap_in;
      free_slot[ckpt.save_idx] <= ckpt.free_snap_in;
    end
  end

  // Restore side reads continuously
  assign ckpt.map_snap_out  = map_slot[ckpt.restore_idx];
  assign ckpt.free_snap_out = free_slot[ckpt.restore_idx];

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // A slot cannot be rewritten while it is being restored
  a_save_restore_slot: assert property (
    @(posedge clock) disable iff (reset)
      (ckpt.save && ckpt.restore) |-> (ckpt.save_idx != ckpt.restore_idx)
  );

endmodule

//--- verilog/free_list.sv
//////////////////////////////////////////////////////////////////////
// Free list of physical registers
// Lowest-first allocation for two slots, stall decision,
// retire frees and union rule on recovery
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module free_list (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                     alloc_req,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    alloc_prf,
  output logic                                                    stall,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                     retire_valid,
  input  rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    retire_prf,
  ckpt_if.free_side                                               ckpt
);

  import rename_pkg::*;

  phys_vec_t   free_q;
  phys_vec_t   free_d;
  free_count_t count_q;
  free_count_t count_d;

  phys_idx_t   first_free;
  phys_idx_t   second_free;
  logic [1:0]  req_count;

  phys_vec_t   retire_vec;
  phys_vec_t   grant_vec;

  //////////////////////////////////////////////////////////////////////
  // Allocation from the registered vector
  //////////////////////////////////////////////////////////////////////

  // Scan down so the last two hits are the lowest two
  always_comb begin
    first_free  = '0;
    second_free = '0;
    for (int i = PHYS_REGS - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        second_free = first_free;
        first_free  = phys_idx_t'(i);
      end
    end
  end

  // Requesting slots take free registers in slot order
  assign alloc_prf[0] = first_free;
  assign alloc_prf[1] = alloc_req[0] ? second_free : first_free;

  assign req_count = {1'b0, alloc_req[0]} + {1'b0, alloc_req[1]};
  assign stall     = free_count_t'(req_count) > count_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    retire_vec = '0;
    grant_vec  = '0;
    count_d    = count_q;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      if (retire_valid[s]) begin
        retire_vec[retire_prf[s]] = 1'b1;
        count_d = count_d + 1'b1;
      end
      if (alloc_req[s] && !stall) begin
        grant_vec[alloc_prf[s]] = 1'b1;
        count_d = count_d - 1'b1;
      end
    end
    if (ckpt.restore) begin
      // Union keeps anything freed since the snapshot
      free_d  = ckpt.free_snap_out | free_q | retire_vec;
      count_d = free_count_t'($countones(free_d));
    end else begin
      free_d = (free_q | retire_vec) & ~grant_vec;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free_q  <= FREE_RESET;
      count_q <= FREE_RESET_COUNT;
    end else begin
      free_q  <= free_d;
      count_q <= count_d;
    end
  end

  assign ckpt.free_snap_in = free_q;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  for (genvar s = 0; s < RENAME_WIDTH; s++) begin : g_check
    a_grant_free: assert property (
      @(posedge clock) disable iff (reset)
        (alloc_req[s] && !stall) |-> (free_q[alloc_prf[s]] && alloc_prf[s] != '0)
    );
    // Retire must hand back a register that was in use
    a_retire_busy: assert property (
      @(posedge clock) disable iff (reset)
        retire_valid[s] |-> !free_q[retire_prf[s]]
    );
  end

endmodule

//--- verilog/map_table.sv
//////////////////////////////////////////////////////////////////////
// Architectural to physical map
// In-group bypass from slot 0 to slot 1, registered rename results
// and restore from a snapshot
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module map_table (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic                                                    group_valid,
  input  logic                                                    recover,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                     rd_write,
  input  rename_pkg::arch_idx_t [rename_pkg::RENAME_WIDTH-1:0]    rd,
  input  rename_pkg::arch_idx_t [rename_pkg::RENAME_WIDTH-1:0]    rs1,
  input  rename_pkg::arch_idx_t [rename_pkg::RENAME_WIDTH-1:0]    rs2,
  output logic [rename_pkg::RENAME_WIDTH-1:0]                     alloc_req,
  input  rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    alloc_prf,
  input  logic                                                    stall,
  output logic                                                    out_valid,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prs1,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prs2,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prd,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prev_prd,
  ckpt_if.map_side                                                ckpt
);

  import rename_pkg::*;

  map_t                         map_q;
  map_t                         map_d;
  logic                         accept;
  phys_idx_t [RENAME_WIDTH-1:0] src1_d;
  phys_idx_t [RENAME_WIDTH-1:0] src2_d;
  phys_idx_t [RENAME_WIDTH-1:0] prev_d;
  phys_idx_t [RENAME_WIDTH-1:0] dst_d;

  // Map read with an optional override from an earlier slot's write
  function automatic phys_idx_t lookup(map_t m, logic hit_en, arch_idx_t w,
                                       phys_idx_t w_prf, arch_idx_t a);
    return (hit_en && a == w) ? w_prf : m[a];
  endfunction

  // x0 never takes a register
  always_comb begin
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      alloc_req[s] = group_valid && rd_write[s] && (rd[s] != '0) && !recover;
    end
  end

  assign accept = group_valid && !stall && !recover;

  // Only slot 1 looks back at slot 0
  always_comb begin
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      src1_d[s] = lookup(map_q, s != 0 && alloc_req[0], rd[0], alloc_prf[0], rs1[s]);
      src2_d[s] = lookup(map_q, s != 0 && alloc_req[0], rd[0], alloc_prf[0], rs2[s]);
      prev_d[s] = lookup(map_q, s != 0 && alloc_req[0], rd[0], alloc_prf[0], rd[s]);
      dst_d[s]  = alloc_req[s] ? alloc_prf[s] : prev_d[s];
    end
  end

  // Slot 1 wins when both slots write the same register
  always_comb begin
    map_d = map_q;
    if (accept) begin
      for (int s = 0; s < RENAME_WIDTH; s++) begin
        if (alloc_req[s]) begin
          map_d[rd[s]] = alloc_prf[s];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      map_q     <= MAP_RESET;
      out_valid <= 1'b0;
    end else begin
      map_q     <= recover ? ckpt.map_snap_out : map_d;
      out_valid <= accept;
    end
  end

  // Rename results, one cycle after the group
  always_ff @(posedge clock) begin
    if (accept) begin
      prs1     <= src1_d;
      prs2     <= src2_d;
      prd      <= dst_d;
      prev_prd <= prev_d;
    end
  end

  assign ckpt.map_snap_in = map_q;

  // Two writers in one accepted group never share a new register
  a_distinct_grants: assert property (
    @(posedge clock) disable iff (reset)
      (accept && (&alloc_req)) |-> (alloc_prf[0] != alloc_prf[1])
  );

endmodule

//--- verilog/rename_unit.sv
//////////////////////////////////////////////////////////////////////
// Integer rename stage top level
// Joins map table, free list and checkpoint store
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rename_unit (
  input  logic                                                    clock,
  input  logic                                                    reset,
  input  logic                                                    group_valid,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                     rd_write,
  input  rename_pkg::arch_idx_t [rename_pkg::RENAME_WIDTH-1:0]    rd,
  input  rename_pkg::arch_idx_t [rename_pkg::RENAME_WIDTH-1:0]    rs1,
  input  rename_pkg::arch_idx_t [rename_pkg::RENAME_WIDTH-1:0]    rs2,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                     retire_valid,
  input  rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    retire_prf,
  input  logic                                                    checkpoint,
  input  rename_pkg::ckpt_idx_t                                   checkpoint_idx,
  input  logic                                                    recover,
  input  rename_pkg::ckpt_idx_t                                   recover_idx,
  output logic                                                    stall,
  output logic                                                    out_valid,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prs1,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prs2,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prd,
  output rename_pkg::phys_idx_t [rename_pkg::RENAME_WIDTH-1:0]    prev_prd
);

  import rename_pkg::*;

  logic [RENAME_WIDTH-1:0]      alloc_req;
  phys_idx_t [RENAME_WIDTH-1:0] alloc_prf;

  ckpt_if ckpt ();

  // Checkpoint strobes come straight from the ports
  assign ckpt.save        = checkpoint;
  assign ckpt.save_idx    = checkpoint_idx;
  assign ckpt.restore     = recover;
  assign ckpt.restore_idx = recover_idx;

  checkpoint_store u_store (.clock(clock), .reset(reset), .ckpt(ckpt.store));

  free_list u_free (
    .clock        (clock),
    .reset        (reset),
    .alloc_req    (alloc_req),
    .alloc_prf    (alloc_prf),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire_prf   (retire_prf),
    .ckpt         (ckpt.free_side)
  );

  map_table u_map (
    .clock (clock), .reset (reset), .group_valid (group_valid), .recover (recover),
    .rd_write (rd_write), .rd (rd), .rs1 (rs1), .rs2 (rs2),
    .alloc_req (alloc_req), .alloc_prf (alloc_prf), .stall (stall),
    .out_valid (out_valid), .prs1 (prs1), .prs2 (prs2), .prd (prd),
    .prev_prd (prev_prd), .ckpt (ckpt.map_side)
  );

endmodule

//--- dv/rename_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the integer rename stage
// Directed table of groups with expected stall, seeded random groups,
// reference model of map, free vector and snapshots, watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rename_tb;

  import rename_pkg::*;

  localparam int NUM_RANDOM = 200;

  typedef struct packed {
    logic                         valid;
    logic [1:0]                   write;
    arch_idx_t [RENAME_WIDTH-1:0] rd;
    arch_idx_t [RENAME_WIDTH-1:0] rs1;
    arch_idx_t [RENAME_WIDTH-1:0] rs2;
    logic [1:0]                   ret_valid;
    phys_idx_t [RENAME_WIDTH-1:0] ret_prf;
    logic                         ckpt;
    ckpt_idx_t                    ckpt_idx;
    logic                         rec;
    ckpt_idx_t                    rec_idx;
    logic                         stall;
  } row_t;

  logic clock = 1'b0;
  logic reset;
  logic group_valid;
  logic [RENAME_WIDTH-1:0] rd_write;
  arch_idx_t [RENAME_WIDTH-1:0] rd;
  arch_idx_t [RENAME_WIDTH-1:0] rs1;
  arch_idx_t [RENAME_WIDTH-1:0] rs2;
  logic [RENAME_WIDTH-1:0] retire_valid;
  phys_idx_t [RENAME_WIDTH-1:0] retire_prf;
  logic checkpoint;
  ckpt_idx_t checkpoint_idx;
  logic recover;
  ckpt_idx_t recover_idx;
  logic stall;
  logic out_valid;
  phys_idx_t [RENAME_WIDTH-1:0] prs1;
  phys_idx_t [RENAME_WIDTH-1:0] prs2;
  phys_idx_t [RENAME_WIDTH-1:0] prd;
  phys_idx_t [RENAME_WIDTH-1:0] prev_prd;

  // Reference model state
  map_t        m_map;
  phys_vec_t   m_free;
  map_t        snap_map [CKPT_SLOTS];
  phys_vec_t   snap_free [CKPT_SLOTS];
  logic        exp_valid;
  phys_idx_t [RENAME_WIDTH-1:0] exp_prs1;
  phys_idx_t [RENAME_WIDTH-1:0] exp_prs2;
  phys_idx_t [RENAME_WIDTH-1:0] exp_prd;
  phys_idx_t [RENAME_WIDTH-1:0] exp_prev;
  phys_idx_t   displaced [$];

  row_t        rows [$];
  int          n_rows = 0;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr = 32'he169;

  rename_unit i_rename_unit (
    .clock (clock), .reset (reset), .group_valid (group_valid), .rd_write (rd_write),
    .rd (rd), .rs1 (rs1), .rs2 (rs2), .retire_valid (retire_valid),
    .retire_prf (retire_prf), .checkpoint (checkpoint), .checkpoint_idx (checkpoint_idx),
    .recover (recover), .recover_idx (recover_idx), .stall (stall),
    .out_valid (out_valid), .prs1 (prs1), .prs2 (prs2), .prd (prd), .prev_prd (prev_prd)
  );

  always #4 clock = ~clock;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and random bits
  //////////////////////////////////////////////////////////////////////

  task automatic check_prf(input string name, input phys_idx_t got, input phys_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic phys_idx_t lowest_free(input phys_vec_t v);
    for (int i = 0; i < PHYS_REGS; i++) begin
      if (v[i]) return phys_idx_t'(i);
    end
    return '0;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic model_reset();
    m_free = '0;
    for (int i = 0; i < ARCH_REGS; i++) begin
      m_map[i] = phys_idx_t'(i);
    end
    for (int i = ARCH_REGS; i < PHYS_REGS; i++) begin
      m_free[i] = 1'b1;
    end
    for (int c = 0; c < CKPT_SLOTS; c++) begin
      snap_map[c]  = m_map;
      snap_free[c] = m_free;
    end
    exp_valid = 1'b0;
  endtask

  task automatic model_step(input row_t r, output logic st);
    logic [1:0] req;
    phys_idx_t [1:0] grant;
    map_t view;
    map_t start_map;
    phys_vec_t start_free;
    phys_vec_t left;
    phys_vec_t freed;
    logic accept;
    int n;
    req = '0;
    grant = '0;
    freed = '0;
    n = 0;
    start_map = m_map;
    start_free = m_free;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      req[s] = r.valid && r.write[s] && (r.rd[s] != '0) && !r.rec;
      if (req[s]) n++;
      if (r.ret_valid[s]) freed[r.ret_prf[s]] = 1'b1;
    end
    st = n > $countones(m_free);
    accept = r.valid && !st && !r.rec;
    // Slot 1 reads the map as slot 0 leaves it
    left = m_free;
    view = m_map;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      if (req[s]) begin
        grant[s] = lowest_free(left);
        left[grant[s]] = 1'b0;
      end
      exp_prs1[s] = view[r.rs1[s]];
      exp_prs2[s] = view[r.rs2[s]];
      exp_prev[s] = view[r.rd[s]];
      exp_prd[s]  = req[s] ? grant[s] : exp_prev[s];
      if (req[s]) view[r.rd[s]] = grant[s];
    end
    exp_valid = accept;
    if (r.rec) begin
      m_map  = snap_map[r.rec_idx];
      m_free = snap_free[r.rec_idx] | m_free | freed;
      displaced.delete();
    end else begin
      if (accept) begin
        m_map = view;
        for (int s = 0; s < RENAME_WIDTH; s++) begin
          if (req[s]) displaced.push_back(exp_prev[s]);
        end
      end
      m_free = (accept ? left : m_free) | freed;
    end
    if (r.ckpt) begin
      snap_map[r.ckpt_idx]  = start_map;
      snap_free[r.ckpt_idx] = start_free;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input logic v, input logic [1:0] w,
                         input int rd0, input int a0, input int b0,
                         input int rd1, input int a1, input int b1,
                         input logic [1:0] rv, input int rp0, input int rp1,
                         input logic ck, input int ck_idx,
                         input logic rc, input int rc_idx, input logic st);
    row_t r;
    r.valid = v;
    r.write = w;
    r.rd[0] = arch_idx_t'(rd0);
    r.rs1[0] = arch_idx_t'(a0);
    r.rs2[0] = arch_idx_t'(b0);
    r.rd[1] = arch_idx_t'(rd1);
    r.rs1[1] = arch_idx_t'(a1);
    r.rs2[1] = arch_idx_t'(b1);
    r.ret_valid = rv;
    r.ret_prf[0] = phys_idx_t'(rp0);
    r.ret_prf[1] = phys_idx_t'(rp1);
    r.ckpt = ck;
    r.ckpt_idx = ckpt_idx_t'(ck_idx);
    r.rec = rc;
    r.rec_idx = ckpt_idx_t'(rc_idx);
    r.stall = st;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // No writes, sources map to themselves
    add_row(1, 2'b00, 0, 3, 4, 0, 7, 31, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    // Lowest first allocation, then an x0 write
    add_row(1, 2'b11, 1, 1, 2, 2, 1, 2, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, 2'b11, 0, 0, 0, 3, 2, 1, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    // Slot 1 bypass, with a checkpoint into slot 1
    add_row(1, 2'b11, 5, 5, 3, 5, 5, 5, 2'b00, 0, 0, 1, 1, 0, 0, 0);
    // Use up all but one free register
    for (int i = 0; i < 13; i++) begin
      add_row(1, 2'b11, 6 + 2 * i, 6 + 2 * i, i, 7 + 2 * i, 6 + 2 * i, 7 + 2 * i,
              2'b00, 0, 0, 0, 0, 0, 0, 0);
    end
    add_row(1, 2'b11, 1, 0, 0, 2, 0, 0, 2'b00, 0, 0, 0, 0, 0, 0, 1);
    add_row(1, 2'b01, 1, 1, 0, 2, 2, 0, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    // Frees land one cycle late
    add_row(1, 2'b01, 4, 0, 0, 0, 0, 0, 2'b11, 1, 2, 0, 0, 0, 0, 1);
    add_row(1, 2'b11, 4, 4, 0, 6, 4, 6, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    // Recover drops the group and restores slot 1
    add_row(1, 2'b11, 7, 0, 0, 8, 0, 0, 2'b00, 0, 0, 0, 0, 1, 1, 0);
    add_row(1, 2'b00, 5, 5, 6, 4, 1, 3, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, 2'b11, 5, 5, 1, 6, 5, 6, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    add_row(0, 2'b00, 0, 0, 0, 0, 0, 0, 2'b00, 0, 0, 0, 0, 0, 0, 0);
    n_rows = rows.size();
  endtask

  // Retires only registers that the model holds as busy
  task automatic make_random_row(output row_t r);
    phys_idx_t p;
    r = '0;
    r.valid = take_bits(2) != 0;
    r.write = take_bits(2);
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      r.rd[s]  = arch_idx_t'(take_bits(5));
      r.rs1[s] = arch_idx_t'(take_bits(5));
      r.rs2[s] = arch_idx_t'(take_bits(5));
      if (take_bits(1) != 0 && displaced.size() > 0) begin
        p = displaced.pop_front();
        if (!m_free[p] && !(s == 1 && r.ret_valid[0] && r.ret_prf[0] == p)) begin
          r.ret_valid[s] = 1'b1;
          r.ret_prf[s] = p;
        end
      end
    end
  endtask

  task automatic drive(input row_t r);
    group_valid = r.valid;
    rd_write = r.write;
    rd = r.rd;
    rs1 = r.rs1;
    rs2 = r.rs2;
    retire_valid = r.ret_valid;
    retire_prf = r.ret_prf;
    checkpoint = r.ckpt;
    checkpoint_idx = r.ckpt_idx;
    recover = r.rec;
    recover_idx = r.rec_idx;
  endtask

  task automatic check_outputs();
    check_flag("out_valid", out_valid, exp_valid);
    if (exp_valid) begin
      for (int s = 0; s < RENAME_WIDTH; s++) begin
        check_prf($sformatf("prs1[%0d]", s), prs1[s], exp_prs1[s]);
        check_prf($sformatf("prs2[%0d]", s), prs2[s], exp_prs2[s]);
        check_prf($sformatf("prd[%0d]", s), prd[s], exp_prd[s]);
        check_prf($sformatf("prev_prd[%0d]", s), prev_prd[s], exp_prev[s]);
      end
    end
  endtask

  // One cycle: last group's results, new inputs, then stall mid-cycle
  task automatic run_row(input row_t r, input logic from_table);
    logic st;
    @(posedge clock);
    #1;
    check_outputs();
    drive(r);
    model_step(r, st);
    #2;
    check_flag("stall", stall, from_table ? r.stall : st);
  endtask

  initial begin
    row_t r;
    reset = 1'b1;
    drive('0);
    build_table();
    model_reset();
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      run_row(rows[i], 1'b1);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      make_random_row(r);
      run_row(r, 1'b0);
    end
    run_row('0, 1'b0);
    $display("Checks run: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (n_rows != 0);
    #((n_rows + NUM_RANDOM + 20) * 8);
    $display("Timeout: the test sequence did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- rename.f
verilog/rename_pkg.sv
verilog/ckpt_if.sv
verilog/checkpoint_store.sv
verilog/free_list.sv
verilog/map_table.sv
verilog/rename_unit.sv
dv/rename_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the rename stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f rename.f --top-module rename_tb -o rename_sim

out=$(./obj_dir/rename_sim 2>&1)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
